// ==== all.f ====
rtl/vga_test_pkg.sv
rtl/uart_rx.sv
rtl/seg_decoder.sv
rtl/vga_timing.sv
rtl/test_pattern_gen.sv
rtl/sync_porch.sv
rtl/vga_test_top.sv
dv/tb_vga_test.sv

// ==== dv/tb_vga_test.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_vga_test;

  import vga_test_pkg::*;

  // Tiny frame so a whole frame takes 3000 cycles
  localparam int TOTAL_COLS   = 100;
  localparam int ACTIVE_COLS  = 80;
  localparam int FRONT_H      = 4;
  localparam int BACK_H       = 8;
  localparam int TOTAL_ROWS   = 30;
  localparam int ACTIVE_ROWS  = 20;
  localparam int FRONT_V      = 2;
  localparam int BACK_V       = 3;
  localparam int CLKS_PER_BIT = 8;

  localparam int H_SYNC_FIRST = ACTIVE_COLS + FRONT_H;
  localparam int H_SYNC_LAST  = TOTAL_COLS - BACK_H - 1;
  localparam int V_SYNC_FIRST = ACTIVE_ROWS + FRONT_V;
  localparam int V_SYNC_LAST  = TOTAL_ROWS - BACK_V - 1;
  localparam int FRAME_CYCLES = TOTAL_COLS * TOTAL_ROWS;
  // Each pattern byte costs up to two frames, plus reset, sync and digit tests
  localparam int MAX_CYCLES   = 24 * FRAME_CYCLES;

  logic        i_Clk;
  logic        i_reset;
  logic        rx_line;
  seg_t        seg [NUM_DIGITS];
  vga_out_t    vga;
  logic        prev_hsync = 1'b1;
  logic        prev_vsync = 1'b1;
  logic [31:0] seed = 32'h661e194c;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;

  vga_test_top #(
    .TOTAL_COLS   (TOTAL_COLS),
    .TOTAL_ROWS   (TOTAL_ROWS),
    .ACTIVE_COLS  (ACTIVE_COLS),
    .ACTIVE_ROWS  (ACTIVE_ROWS),
    .FRONT_H      (FRONT_H),
    .BACK_H       (BACK_H),
    .FRONT_V      (FRONT_V),
    .BACK_V       (BACK_V),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) DUT (
    .i_Clk     (i_Clk),
    .i_reset   (i_reset),
    .i_uart_rx (rx_line),
    .o_seg     (seg),
    .o_vga     (vga)
  );

  initial
  begin
    i_Clk = 1'b0;
    forever #20 i_Clk = ~i_Clk;
  end

  // Previous output sample, used to find sync falling edges
  always @(negedge i_Clk)
  begin
    prev_hsync <= vga.hsync;
    prev_vsync <= vga.vsync;
  end

  always @(posedge i_Clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Active-low hex digits, segment a in bit 6
  function automatic logic [6:0] seg_code(input logic [3:0] n);
    case (n)
      4'h0:    return 7'h01;
      4'h1:    return 7'h4F;
      4'h2:    return 7'h12;
      4'h3:    return 7'h06;
      4'h4:    return 7'h4C;
      4'h5:    return 7'h24;
      4'h6:    return 7'h20;
      4'h7:    return 7'h0F;
      4'h8:    return 7'h00;
      4'h9:    return 7'h04;
      4'hA:    return 7'h08;
      4'hB:    return 7'h60;
      4'hC:    return 7'h31;
      4'hD:    return 7'h42;
      4'hE:    return 7'h30;
      default: return 7'h38;
    endcase
  endfunction

  function automatic logic [8:0] expected_pixel(input int code, input int col, input int row);
    logic       in_active;
    logic       on;
    int         idx;
    logic [8:0] pix;
    in_active = (col < ACTIVE_COLS) && (row < ACTIVE_ROWS);
    pix = '0;
    case (code)
      1: pix = in_active ? 9'b111_000_000 : 9'b0;
      2: pix = in_active ? 9'b000_111_000 : 9'b0;
      3: pix = in_active ? 9'b000_000_111 : 9'b0;
      4: pix = (((col >> 5) & 1) != ((row >> 5) & 1)) ? 9'h1FF : 9'h0;
      5:
      begin
        idx = col / (ACTIVE_COLS / 8);
        if (idx > 7)
          idx = 7;
        pix = {{3{idx[2]}}, {3{idx[1]}}, {3{idx[0]}}};
      end
      6:
      begin
        on = (row <= 1) || (row >= ACTIVE_ROWS - 2) || (col <= 1) || (col >= ACTIVE_COLS - 2);
        pix = on ? 9'h1FF : 9'h0;
      end
      default: pix = '0;
    endcase
    return pix;
  endfunction

  function automatic logic sync_level(input logic use_v);
    return use_v ? vga.vsync : vga.hsync;
  endfunction

  function automatic logic fell(input logic use_v);
    if (use_v)
      return prev_vsync && !vga.vsync;
    else
      return prev_hsync && !vga.hsync;
  endfunction

  ////////////////////////////////////////
  // Drivers and checks
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic drive_bit(input logic value);
    @(posedge i_Clk);
    rx_line <= value;
    repeat (CLKS_PER_BIT - 1) @(posedge i_Clk);
  endtask

  // Start bit, eight data bits LSB first, stop bit, then wait for valid
  task automatic send_byte(input logic [7:0] data);
    int waited;
    drive_bit(1'b0);
    for (int b = 0; b < 8; b++)
      drive_bit(data[b]);
    drive_bit(1'b1);
    waited = 0;
    @(negedge i_Clk);
    while (DUT.rx_valid !== 1'b1 && waited < 4 * CLKS_PER_BIT)
    begin
      waited++;
      @(negedge i_Clk);
    end
    if (DUT.rx_valid !== 1'b1)
    begin
      error_count++;
      $display("Receiver gave no valid pulse for byte %02h", data);
    end
  endtask

  task automatic check_digits(input string name, input logic [7:0] data);
    @(negedge i_Clk);
    check_value({name, " digit 0"}, 32'(seg_code(data[7:4])), 32'(seg[0]));
    check_value({name, " digit 1"}, 32'(seg_code(data[3:0])), 32'(seg[1]));
  endtask

  task automatic wait_fall(input logic use_v);
    @(negedge i_Clk);
    while (!fell(use_v))
      @(negedge i_Clk);
  endtask

  task automatic measure_sync(input string name, input logic use_v, input int exp_period,
                              input int exp_low);
    int low_len;
    int period;
    wait_fall(use_v);
    low_len = 0;
    period = 0;
    while (!sync_level(use_v))
    begin
      low_len++;
      period++;
      @(negedge i_Clk);
    end
    while (!fell(use_v))
    begin
      period++;
      @(negedge i_Clk);
    end
    check_value({name, " period"}, 32'(exp_period), 32'(period));
    check_value({name, " low time"}, 32'(exp_low), 32'(low_len));
  endtask

  // One frame from the vsync fall, where the position is column 0 of the first sync row
  task automatic check_frame(input string name, input int code);
    int   col;
    int   row;
    int   first_errors;
    logic exp_h;
    logic exp_v;
    wait_fall(1'b1);
    col = 0;
    row = V_SYNC_FIRST;
    first_errors = error_count;
    for (int i = 0; i < FRAME_CYCLES && error_count == first_errors; i++)
    begin
      if (i > 0)
      begin
        @(negedge i_Clk);
        col++;
        if (col == TOTAL_COLS)
        begin
          col = 0;
          row = (row + 1) % TOTAL_ROWS;
        end
      end
      exp_h = !(col >= H_SYNC_FIRST && col <= H_SYNC_LAST);
      exp_v = !(row >= V_SYNC_FIRST && row <= V_SYNC_LAST);
      check_value($sformatf("%s pixel at %0d,%0d", name, col, row),
                  32'(expected_pixel(code, col, row)), 32'(vga.pixel));
      check_value($sformatf("%s hsync at %0d,%0d", name, col, row), 32'(exp_h), 32'(vga.hsync));
      check_value($sformatf("%s vsync at %0d,%0d", name, col, row), 32'(exp_v), 32'(vga.vsync));
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic verify_reset_state();
    @(negedge i_Clk);
    check_value("reset digit 0", 32'h7F, 32'(seg[0]));
    check_value("reset digit 1", 32'h7F, 32'(seg[1]));
    check_frame("reset frame", 0);
  endtask

  task automatic measure_sync_timing();
    measure_sync("hsync", 1'b0, TOTAL_COLS, TOTAL_COLS - ACTIVE_COLS - FRONT_H - BACK_H);
    measure_sync("vsync", 1'b1, FRAME_CYCLES,
                 (TOTAL_ROWS - ACTIVE_ROWS - FRONT_V - BACK_V) * TOTAL_COLS);
  endtask

  task automatic show_random_digits();
    logic [7:0] data;
    for (int n = 0; n < 5; n++)
    begin
      seed = lcg_next(seed);
      data = seed[23:16];
      repeat (seed[5:0]) @(posedge i_Clk);
      send_byte(data);
      check_digits($sformatf("random byte %02h", data), data);
    end
  endtask

  task automatic solid_colour_frames();
    for (int code = 1; code <= 3; code++)
    begin
      send_byte(8'(code));
      check_frame($sformatf("solid code %0d", code), code);
    end
  endtask

  task automatic spatial_pattern_frames();
    send_byte(8'h04);
    check_frame("checker", 4);
    send_byte(8'h35);
    check_digits("bars byte", 8'h35);
    check_frame("bars", 5);
    send_byte(8'h06);
    check_frame("border", 6);
  endtask

  task automatic unused_code_frames();
    logic [7:0] codes [2];
    codes[0] = 8'h0A;
    codes[1] = 8'hFF;
    foreach (codes[n])
    begin
      send_byte(codes[n]);
      check_digits($sformatf("unused byte %02h", codes[n]), codes[n]);
      check_frame($sformatf("unused byte %02h", codes[n]), int'(codes[n][3:0]));
    end
  endtask

  initial
  begin
    i_reset <= 1'b1;
    rx_line <= 1'b1;
    repeat (2) @(posedge i_Clk);
    i_reset <= 1'b0;

    verify_reset_state();
    measure_sync_timing();
    show_random_digits();
    solid_colour_frames();
    spatial_pattern_frames();
    unused_code_frames();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/seg_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg_decoder (
  input  logic                i_Clk,
  input  logic                i_reset,
  input  logic                i_load,
  input  logic [3:0]          i_nibble,
  output vga_test_pkg::seg_t  o_seg
);

  import vga_test_pkg::*;

  // Lit segments, a in bit 6
  logic [6:0] seg_on;

  always_comb
  begin
    case (i_nibble)
      4'h0:    seg_on = 7'b1111110;
      4'h1:    seg_on = 7'b0110000;
      4'h2:    seg_on = 7'b1101101;
      4'h3:    seg_on = 7'b1111001;
      4'h4:    seg_on = 7'b0110011;
      4'h5:    seg_on = 7'b1011011;
      4'h6:    seg_on = 7'b1011111;
      4'h7:    seg_on = 7'b1110000;
      4'h8:    seg_on = 7'b1111111;
      4'h9:    seg_on = 7'b1111011;
      4'hA:    seg_on = 7'b1110111;
      4'hB:    seg_on = 7'b0011111;
      4'hC:    seg_on = 7'b1001110;
      4'hD:    seg_on = 7'b0111101;
      4'hE:    seg_on = 7'b1001111;
      default: seg_on = 7'b1000111;
    endcase
  end

  // Blank after reset, the display is driven low to light a segment
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
      o_seg <= seg_t'(7'h7F);
    else if (i_load)
      o_seg <= seg_t'(~seg_on);
  end

endmodule

`default_nettype wire

// ==== rtl/sync_porch.sv ====
`timescale 1ns/10ps
`default_nettype none

module sync_porch #(
  parameter int TOTAL_COLS  = 800,
  parameter int TOTAL_ROWS  = 525,
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480,
  parameter int FRONT_H     = 18,
  parameter int BACK_H      = 50,
  parameter int FRONT_V     = 10,
  parameter int BACK_V      = 33
) (
  input  logic                    i_Clk,
  input  logic                    i_reset,
  input  vga_test_pkg::raster_t   i_pos,
  input  vga_test_pkg::pixel_t    i_pixel,
  output vga_test_pkg::vga_out_t  o_vga
);

  import vga_test_pkg::*;

  // Sync pulse spans, inclusive
  localparam int H_SYNC_FIRST = ACTIVE_COLS + FRONT_H;
  localparam int H_SYNC_LAST  = TOTAL_COLS - BACK_H - 1;
  localparam int V_SYNC_FIRST = ACTIVE_ROWS + FRONT_V;
  localparam int V_SYNC_LAST  = TOTAL_ROWS - BACK_V - 1;

  logic hsync_low;
  logic vsync_low;

  assign hsync_low = (int'(i_pos.col) >= H_SYNC_FIRST) && (int'(i_pos.col) <= H_SYNC_LAST);
  assign vsync_low = (int'(i_pos.row) >= V_SYNC_FIRST) && (int'(i_pos.row) <= V_SYNC_LAST);

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      o_vga.hsync <= 1'b1;
      o_vga.vsync <= 1'b1;
      o_vga.pixel <= '0;
    end
    else
    begin
      o_vga.hsync <= !hsync_low;
      o_vga.vsync <= !vsync_low;
      o_vga.pixel <= i_pixel;
    end
  end

  // Sync pulse must fit inside blanking with room left between the porches
  a_porch_h : assert property (@(posedge i_Clk)
    (FRONT_H + BACK_H) < (TOTAL_COLS - ACTIVE_COLS));
  a_porch_v : assert property (@(posedge i_Clk)
    (FRONT_V + BACK_V) < (TOTAL_ROWS - ACTIVE_ROWS));

endmodule

`default_nettype wire

// ==== rtl/test_pattern_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module test_pattern_gen #(
  parameter int ACTIVE_COLS = 640,
  parameter int ACTIVE_ROWS = 480
) (
  input  logic                   i_Clk,
  input  logic                   i_reset,
  input  logic                   i_load,
  input  logic [3:0]             i_code,
  input  vga_test_pkg::raster_t  i_pos,
  output vga_test_pkg::raster_t  o_pos,
  output vga_test_pkg::pixel_t   o_pixel
);

  import vga_test_pkg::*;

  localparam int BAR_W = ACTIVE_COLS / 8;
  localparam logic [COUNT_W-1:0] COL_ACT = COUNT_W'(ACTIVE_COLS);
  localparam logic [COUNT_W-1:0] ROW_ACT = COUNT_W'(ACTIVE_ROWS);
  localparam logic [COUNT_W-1:0] COL_EDGE = COUNT_W'(ACTIVE_COLS - 2);
  localparam logic [COUNT_W-1:0] ROW_EDGE = COUNT_W'(ACTIVE_ROWS - 2);
  localparam logic [COLOR_W-1:0] FULL = {COLOR_W{1'b1}};

  pattern_e           pattern_q;
  logic               in_active;
  logic               checker_on;
  logic               border_on;
  logic [COUNT_W-1:0] bar_num;
  logic [2:0]         bar_idx;
  pixel_t             pix_next;

  // Unused codes fall back to off
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
      pattern_q <= PAT_OFF;
    else if (i_load)
      pattern_q <= (i_code <= 4'd6) ? pattern_e'(i_code) : PAT_OFF;
  end

  ////////////////////////////////////////
  // Per-position terms
  ////////////////////////////////////////

  assign in_active  = (i_pos.col < COL_ACT) && (i_pos.row < ROW_ACT);
  assign checker_on = i_pos.col[5] ^ i_pos.row[5];
  assign border_on  = (i_pos.row <= 1) || (i_pos.row >= ROW_EDGE) ||
                      (i_pos.col <= 1) || (i_pos.col >= COL_EDGE);

  // Eight bars across the active width, the last one runs to the line end
  assign bar_num = COUNT_W'(i_pos.col / BAR_W);
  assign bar_idx = (bar_num > 7) ? 3'd7 : bar_num[2:0];

  always_comb
  begin
    pix_next = '0;
    case (pattern_q)
      PAT_RED:
        pix_next.red = in_active ? FULL : '0;
      PAT_GREEN:
        pix_next.green = in_active ? FULL : '0;
      PAT_BLUE:
        pix_next.blue = in_active ? FULL : '0;
      PAT_CHECKER:
      begin
        pix_next.red   = checker_on ? FULL : '0;
        pix_next.green = checker_on ? FULL : '0;
        pix_next.blue  = checker_on ? FULL : '0;
      end
      PAT_BARS:
      begin
        pix_next.red   = {COLOR_W{bar_idx[2]}};
        pix_next.green = {COLOR_W{bar_idx[1]}};
        pix_next.blue  = {COLOR_W{bar_idx[0]}};
      end
      PAT_BORDER:
      begin
        pix_next.red   = border_on ? FULL : '0;
        pix_next.green = border_on ? FULL : '0;
        pix_next.blue  = border_on ? FULL : '0;
      end
      default:
        pix_next = '0;
    endcase
  end

  // Colour leaves together with its own position
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      o_pos   <= '0;
      o_pixel <= '0;
    end
    else
    begin
      o_pos   <= i_pos;
      o_pixel <= pix_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 217
) (
  input  logic       i_Clk,
  input  logic       i_reset,
  input  logic       i_uart_rx,
  output logic       o_rx_valid,
  output logic [7:0] o_rx_byte
);

  import vga_test_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2);

  rx_state_e        state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  logic             rx_meta_q;
  logic             rx_sync_q;

  // Two-flop synchronizer, the line idles high
  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end
    else
    begin
      rx_meta_q <= i_uart_rx;
      rx_sync_q <= rx_meta_q;
    end
  end

  ////////////////////////////////////////
  // Receive FSM
  ////////////////////////////////////////

  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      state_q    <= RX_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      o_rx_valid <= 1'b0;
    end
    else
    begin
      case (state_q)
        RX_IDLE:
        begin
          o_rx_valid <= 1'b0;
          clk_cnt_q  <= '0;
          bit_idx_q  <= '0;
          if (!rx_sync_q)
            state_q <= RX_START;
        end
        RX_START:
        begin
          // Recheck the start bit at its middle, a glitch goes back to idle
          if (clk_cnt_q == HALF_BIT)
          begin
            clk_cnt_q <= '0;
            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;
          end
          else
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
        RX_DATA:
        begin
          if (clk_cnt_q == BIT_LAST)
          begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7)
              state_q <= RX_STOP;
          end
          else
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
        RX_STOP:
        begin
          if (clk_cnt_q == BIT_LAST)
          begin
            clk_cnt_q  <= '0;
            o_rx_valid <= 1'b1;
            state_q    <= RX_DONE;
          end
          else
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
        RX_DONE:
        begin
          o_rx_valid <= 1'b0;
          state_q    <= RX_IDLE;
        end
        default:
          state_q <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive least significant first
  always_ff @(posedge i_Clk)
  begin
    if (state_q == RX_DATA && clk_cnt_q == BIT_LAST)
      o_rx_byte[bit_idx_q] <= rx_sync_q;
  end

  a_valid_single : assert property (@(posedge i_Clk) disable iff (i_reset)
    o_rx_valid |=> !o_rx_valid);

endmodule

`default_nettype wire

// ==== rtl/vga_test_pkg.sv ====
`default_nettype none

package vga_test_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Counter width covers frames up to 1024 in each direction
  localparam int COUNT_W    = 10;
  localparam int COLOR_W    = 3;
  localparam int NUM_DIGITS = 2;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // One raster position
  typedef struct packed {
    logic [COUNT_W-1:0] col;
    logic [COUNT_W-1:0] row;
  } raster_t;

  typedef struct packed {
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } pixel_t;

  // Sync levels and video of one output sample
  typedef struct packed {
    logic   hsync;
    logic   vsync;
    pixel_t pixel;
  } vga_out_t;

  // Segments a to g, active low, a in the top bit
  typedef struct packed {
    logic a;
    logic b;
    logic c;
    logic d;
    logic e;
    logic f;
    logic g;
  } seg_t;

  ////////////////////////////////////////
  // Enums
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    PAT_OFF     = 4'd0,
    PAT_RED     = 4'd1,
    PAT_GREEN   = 4'd2,
    PAT_BLUE    = 4'd3,
    PAT_CHECKER = 4'd4,
    PAT_BARS    = 4'd5,
    PAT_BORDER  = 4'd6
  } pattern_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_DONE
  } rx_state_e;

endpackage

`default_nettype wire

// ==== rtl/vga_test_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_test_top #(
  parameter int TOTAL_COLS   = 800,
  parameter int TOTAL_ROWS   = 525,
  parameter int ACTIVE_COLS  = 640,
  parameter int ACTIVE_ROWS  = 480,
  parameter int FRONT_H      = 18,
  parameter int BACK_H       = 50,
  parameter int FRONT_V      = 10,
  parameter int BACK_V       = 33,
  parameter int CLKS_PER_BIT = 217
) (
  input  logic                    i_Clk,
  input  logic                    i_reset,
  input  logic                    i_uart_rx,
  output vga_test_pkg::seg_t      o_seg [vga_test_pkg::NUM_DIGITS],
  output vga_test_pkg::vga_out_t  o_vga
);

  import vga_test_pkg::*;

  logic       rx_valid;
  logic [7:0] rx_byte;
  raster_t    pos_count;
  raster_t    pos_pattern;
  pixel_t     pixel_pattern;

  ////////////////////////////////////////
  // Serial input and digits
  ////////////////////////////////////////

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_uart_rx (
    .i_Clk      (i_Clk),
    .i_reset    (i_reset),
    .i_uart_rx  (i_uart_rx),
    .o_rx_valid (rx_valid),
    .o_rx_byte  (rx_byte)
  );

  // Digit 0 takes the high nibble
  for (genvar k = 0; k < NUM_DIGITS; k++)
  begin : g_digit
    seg_decoder u_seg_decoder (
      .i_Clk    (i_Clk),
      .i_reset  (i_reset),
      .i_load   (rx_valid),
      .i_nibble (rx_byte[7-4*k -: 4]),
      .o_seg    (o_seg[k])
    );
  end

  ////////////////////////////////////////
  // Video path
  ////////////////////////////////////////

  vga_timing #(
    .TOTAL_COLS (TOTAL_COLS),
    .TOTAL_ROWS (TOTAL_ROWS)
  ) u_vga_timing (
    .i_Clk   (i_Clk),
    .i_reset (i_reset),
    .o_pos   (pos_count)
  );

  test_pattern_gen #(
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS)
  ) u_test_pattern_gen (
    .i_Clk   (i_Clk),
    .i_reset (i_reset),
    .i_load  (rx_valid),
    .i_code  (rx_byte[3:0]),
    .i_pos   (pos_count),
    .o_pos   (pos_pattern),
    .o_pixel (pixel_pattern)
  );

  sync_porch #(
    .TOTAL_COLS  (TOTAL_COLS),
    .TOTAL_ROWS  (TOTAL_ROWS),
    .ACTIVE_COLS (ACTIVE_COLS),
    .ACTIVE_ROWS (ACTIVE_ROWS),
    .FRONT_H     (FRONT_H),
    .BACK_H      (BACK_H),
    .FRONT_V     (FRONT_V),
    .BACK_V      (BACK_V)
  ) u_sync_porch (
    .i_Clk   (i_Clk),
    .i_reset (i_reset),
    .i_pos   (pos_pattern),
    .i_pixel (pixel_pattern),
    .o_vga   (o_vga)
  );

endmodule

`default_nettype wire

// ==== rtl/vga_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module vga_timing #(
  parameter int TOTAL_COLS = 800,
  parameter int TOTAL_ROWS = 525
) (
  input  logic                   i_Clk,
  input  logic                   i_reset,
  output vga_test_pkg::raster_t  o_pos
);

  import vga_test_pkg::*;

  localparam logic [COUNT_W-1:0] COL_LAST = COUNT_W'(TOTAL_COLS - 1);
  localparam logic [COUNT_W-1:0] ROW_LAST = COUNT_W'(TOTAL_ROWS - 1);

  logic col_wrap;
  logic row_wrap;

  assign col_wrap = (o_pos.col == COL_LAST);
  assign row_wrap = (o_pos.row == ROW_LAST);

  ////////////////////////////////////////
  // Raster counters
  ////////////////////////////////////////

  always_ff @(posedge i_Clk)
  begin
    if (i_reset)
    begin
      o_pos <= '0;
    end
    else if (col_wrap)
    begin
      o_pos.col <= '0;
      // Row steps once per line
      if (row_wrap)
        o_pos.row <= '0;
      else
        o_pos.row <= o_pos.row + 1'b1;
    end
    else
    begin
      o_pos.col <= o_pos.col + 1'b1;
    end
  end

  a_pos_in_frame : assert property (@(posedge i_Clk) disable iff (i_reset)
    (int'(o_pos.col) < TOTAL_COLS) && (int'(o_pos.row) < TOTAL_ROWS));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_vga_test -o sim_tb_vga_test

output=$(./obj_dir/sim_tb_vga_test)
printf '%s\n' "$output"

# Exit status follows the search result
printf '%s\n' "$output" | grep -qx "TEST PASS"
